// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_exec_core
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= TEST FAIL
PASS_MSG  ?= TEST PASS
VFLAGS    ?= --binary --assert --timing -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: alu.sv
`timescale 1ns/1ps

module alu (
	input  logic [mips_isa_pkg::XLEN-1:0]   a,
	input  logic [mips_isa_pkg::XLEN-1:0]   b,
	input  logic [mips_isa_pkg::REG_AW-1:0] shamt,
	input  logic                            shift_by_shamt,
	input  mips_ctrl_pkg::alu_op_e          alu_op,
	input  mips_ctrl_pkg::branch_e          branch,
	input  logic [mips_isa_pkg::XLEN-1:0]   hi,
	input  logic [mips_isa_pkg::XLEN-1:0]   lo,
	output logic [mips_isa_pkg::XLEN-1:0]   result,
	output logic                            taken
);

	logic [mips_isa_pkg::REG_AW-1:0] shift_amt;
	logic signed [mips_isa_pkg::XLEN-1:0] a_s;
	logic signed [mips_isa_pkg::XLEN-1:0] b_s;

	assign shift_amt = shift_by_shamt ? shamt : a[mips_isa_pkg::REG_AW-1:0];
	assign a_s = a;
	assign b_s = b;

	always_comb begin
		result = '0;
		case (alu_op)
			mips_ctrl_pkg::ALU_ADD:     result = a + b;
			mips_ctrl_pkg::ALU_SUB:     result = a - b;
			mips_ctrl_pkg::ALU_AND:     result = a & b;
			mips_ctrl_pkg::ALU_OR:      result = a | b;
			mips_ctrl_pkg::ALU_XOR:     result = a ^ b;
			mips_ctrl_pkg::ALU_NOR:     result = ~(a | b);
			mips_ctrl_pkg::ALU_SLT:     result[0] = (a_s < b_s);
			mips_ctrl_pkg::ALU_SLTU:    result[0] = (a < b);
			mips_ctrl_pkg::ALU_SLL:     result = b << shift_amt;	// Shifts act on rt
			mips_ctrl_pkg::ALU_SRL:     result = b >> shift_amt;
			mips_ctrl_pkg::ALU_SRA:     result = b_s >>> shift_amt;
			mips_ctrl_pkg::ALU_LUI: begin
				result = {b[mips_isa_pkg::IMM_W-1:0], {mips_isa_pkg::IMM_W{1'b0}}};
			end
			mips_ctrl_pkg::ALU_PASS_HI: result = hi;
			mips_ctrl_pkg::ALU_PASS_LO: result = lo;
			default:                    result = a + b;
		endcase
	end

	// Branch condition on rs, and rt for BEQ/BNE
	always_comb begin
		case (branch)
			mips_ctrl_pkg::BR_EQ:  taken = (a == b);
			mips_ctrl_pkg::BR_NE:  taken = (a != b);
			mips_ctrl_pkg::BR_LEZ: taken = (a_s <= 0);
			mips_ctrl_pkg::BR_GTZ: taken = (a_s > 0);
			mips_ctrl_pkg::BR_LTZ: taken = a[mips_isa_pkg::XLEN-1];
			mips_ctrl_pkg::BR_GEZ: taken = ~a[mips_isa_pkg::XLEN-1];
			default:               taken = 1'b0;
		endcase
	end

endmodule

// File: control_unit.sv
`timescale 1ns/1ps

module control_unit (
	input  logic [mips_isa_pkg::XLEN-1:0]   instr,
	output mips_ctrl_pkg::ctrl_t            ctrl,
	output logic [mips_isa_pkg::REG_AW-1:0] rs_idx,
	output logic [mips_isa_pkg::REG_AW-1:0] rt_idx,
	output logic [mips_isa_pkg::REG_AW-1:0] rd_sel,
	output logic [mips_isa_pkg::XLEN-1:0]   imm,
	output logic [mips_isa_pkg::REG_AW-1:0] shamt
);

	mips_isa_pkg::opcode_e op;
	mips_isa_pkg::funct_e  funct;
	logic [mips_isa_pkg::REG_AW-1:0] rd_idx;
	logic [mips_isa_pkg::IMM_W-1:0]  imm16;
	logic                            zero_ext;

	assign op     = mips_isa_pkg::opcode_e'(instr[mips_isa_pkg::OP_LSB +: mips_isa_pkg::OP_W]);
	assign funct  = mips_isa_pkg::funct_e'(instr[mips_isa_pkg::FUNCT_LSB +: mips_isa_pkg::FUNCT_W]);
	assign rs_idx = instr[mips_isa_pkg::RS_LSB +: mips_isa_pkg::REG_AW];
	assign rt_idx = instr[mips_isa_pkg::RT_LSB +: mips_isa_pkg::REG_AW];
	assign rd_idx = instr[mips_isa_pkg::RD_LSB +: mips_isa_pkg::REG_AW];
	assign shamt  = instr[mips_isa_pkg::SHAMT_LSB +: mips_isa_pkg::REG_AW];
	assign imm16  = instr[mips_isa_pkg::IMM_LSB +: mips_isa_pkg::IMM_W];

	// Only the logical immediates are zero-extended
	assign zero_ext = (op == mips_isa_pkg::OP_ANDI) || (op == mips_isa_pkg::OP_ORI) ||
		(op == mips_isa_pkg::OP_XORI);
	assign imm = zero_ext ? {{(mips_isa_pkg::XLEN-mips_isa_pkg::IMM_W){1'b0}}, imm16} :
		{{(mips_isa_pkg::XLEN-mips_isa_pkg::IMM_W){imm16[mips_isa_pkg::IMM_W-1]}}, imm16};

	assign rd_sel = (op == mips_isa_pkg::OP_SPECIAL) ? rd_idx : rt_idx;

	always_comb begin
		ctrl.reg_write      = 1'b0;
		ctrl.use_imm        = 1'b0;
		ctrl.shift_by_shamt = 1'b0;
		ctrl.alu_op         = mips_ctrl_pkg::ALU_ADD;
		ctrl.branch         = mips_ctrl_pkg::BR_NONE;
		ctrl.hilo_op        = mips_ctrl_pkg::HL_NONE;
		ctrl.illegal        = 1'b0;
		case (op)
			mips_isa_pkg::OP_SPECIAL: begin
				ctrl.reg_write = 1'b1;
				case (funct)
					mips_isa_pkg::FN_ADD, mips_isa_pkg::FN_ADDU: ctrl.alu_op = mips_ctrl_pkg::ALU_ADD;
					mips_isa_pkg::FN_SUB, mips_isa_pkg::FN_SUBU: ctrl.alu_op = mips_ctrl_pkg::ALU_SUB;
					mips_isa_pkg::FN_AND:  ctrl.alu_op = mips_ctrl_pkg::ALU_AND;
					mips_isa_pkg::FN_OR:   ctrl.alu_op = mips_ctrl_pkg::ALU_OR;
					mips_isa_pkg::FN_XOR:  ctrl.alu_op = mips_ctrl_pkg::ALU_XOR;
					mips_isa_pkg::FN_NOR:  ctrl.alu_op = mips_ctrl_pkg::ALU_NOR;
					mips_isa_pkg::FN_SLT:  ctrl.alu_op = mips_ctrl_pkg::ALU_SLT;
					mips_isa_pkg::FN_SLTU: ctrl.alu_op = mips_ctrl_pkg::ALU_SLTU;
					mips_isa_pkg::FN_SLL: begin
						ctrl.alu_op         = mips_ctrl_pkg::ALU_SLL;
						ctrl.shift_by_shamt = 1'b1;
					end
					mips_isa_pkg::FN_SRL: begin
						ctrl.alu_op         = mips_ctrl_pkg::ALU_SRL;
						ctrl.shift_by_shamt = 1'b1;
					end
					mips_isa_pkg::FN_SRA: begin
						ctrl.alu_op         = mips_ctrl_pkg::ALU_SRA;
						ctrl.shift_by_shamt = 1'b1;
					end
					mips_isa_pkg::FN_MFHI: ctrl.alu_op = mips_ctrl_pkg::ALU_PASS_HI;
					mips_isa_pkg::FN_MFLO: ctrl.alu_op = mips_ctrl_pkg::ALU_PASS_LO;
					mips_isa_pkg::FN_MULT, mips_isa_pkg::FN_MULTU,
					mips_isa_pkg::FN_DIV, mips_isa_pkg::FN_DIVU,
					mips_isa_pkg::FN_MTHI, mips_isa_pkg::FN_MTLO: begin
						ctrl.reg_write = 1'b0;		// Result goes to HI/LO only
						case (funct)
							mips_isa_pkg::FN_MULT:  ctrl.hilo_op = mips_ctrl_pkg::HL_MULT;
							mips_isa_pkg::FN_MULTU: ctrl.hilo_op = mips_ctrl_pkg::HL_MULTU;
							mips_isa_pkg::FN_DIV:   ctrl.hilo_op = mips_ctrl_pkg::HL_DIV;
							mips_isa_pkg::FN_DIVU:  ctrl.hilo_op = mips_ctrl_pkg::HL_DIVU;
							mips_isa_pkg::FN_MTHI:  ctrl.hilo_op = mips_ctrl_pkg::HL_MTHI;
							default:                ctrl.hilo_op = mips_ctrl_pkg::HL_MTLO;
						endcase
					end
					default: begin
						ctrl.reg_write = 1'b0;
						ctrl.illegal   = 1'b1;
					end
				endcase
			end
			mips_isa_pkg::OP_REGIMM: begin
				case (rt_idx)
					mips_isa_pkg::REGIMM_BLTZ: ctrl.branch = mips_ctrl_pkg::BR_LTZ;
					mips_isa_pkg::REGIMM_BGEZ: ctrl.branch = mips_ctrl_pkg::BR_GEZ;
					default:                   ctrl.illegal = 1'b1;	// Linking forms unsupported
				endcase
			end
			mips_isa_pkg::OP_BEQ:  ctrl.branch = mips_ctrl_pkg::BR_EQ;
			mips_isa_pkg::OP_BNE:  ctrl.branch = mips_ctrl_pkg::BR_NE;
			mips_isa_pkg::OP_BLEZ: ctrl.branch = mips_ctrl_pkg::BR_LEZ;
			mips_isa_pkg::OP_BGTZ: ctrl.branch = mips_ctrl_pkg::BR_GTZ;
			mips_isa_pkg::OP_ADDI, mips_isa_pkg::OP_ADDIU, mips_isa_pkg::OP_SLTI,
			mips_isa_pkg::OP_SLTIU, mips_isa_pkg::OP_ANDI, mips_isa_pkg::OP_ORI,
			mips_isa_pkg::OP_XORI, mips_isa_pkg::OP_LUI: begin
				ctrl.reg_write = 1'b1;
				ctrl.use_imm   = 1'b1;
				case (op)
					mips_isa_pkg::OP_SLTI:  ctrl.alu_op = mips_ctrl_pkg::ALU_SLT;
					mips_isa_pkg::OP_SLTIU: ctrl.alu_op = mips_ctrl_pkg::ALU_SLTU;
					mips_isa_pkg::OP_ANDI:  ctrl.alu_op = mips_ctrl_pkg::ALU_AND;
					mips_isa_pkg::OP_ORI:   ctrl.alu_op = mips_ctrl_pkg::ALU_OR;
					mips_isa_pkg::OP_XORI:  ctrl.alu_op = mips_ctrl_pkg::ALU_XOR;
					mips_isa_pkg::OP_LUI:   ctrl.alu_op = mips_ctrl_pkg::ALU_LUI;
					default:                ctrl.alu_op = mips_ctrl_pkg::ALU_ADD;
				endcase
			end
			default: ctrl.illegal = 1'b1;
		endcase
	end

endmodule

// File: exec_core.sv
`timescale 1ns/1ps

module exec_core (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          instr_valid,
	input  logic [mips_isa_pkg::XLEN-1:0] instr,
	output logic                          retire_valid,
	output mips_ctrl_pkg::retire_t        retire
);

	mips_ctrl_pkg::ctrl_t            ctrl;
	mips_ctrl_pkg::retire_t          rec_next;
	logic [mips_isa_pkg::REG_AW-1:0] rs_idx;
	logic [mips_isa_pkg::REG_AW-1:0] rt_idx;
	logic [mips_isa_pkg::REG_AW-1:0] rd_sel;
	logic [mips_isa_pkg::REG_AW-1:0] shamt;
	logic [mips_isa_pkg::XLEN-1:0]   imm;
	logic [mips_isa_pkg::XLEN-1:0]   rs_data;
	logic [mips_isa_pkg::XLEN-1:0]   rt_data;
	logic [mips_isa_pkg::XLEN-1:0]   op_b;
	logic [mips_isa_pkg::XLEN-1:0]   result;
	logic [mips_isa_pkg::XLEN-1:0]   hi;
	logic [mips_isa_pkg::XLEN-1:0]   lo;
	logic                            taken;

	control_unit u_control (
		.instr  (instr),
		.ctrl   (ctrl),
		.rs_idx (rs_idx),
		.rt_idx (rt_idx),
		.rd_sel (rd_sel),
		.imm    (imm),
		.shamt  (shamt)
	);

	register_file u_regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs_idx  (rs_idx),
		.rt_idx  (rt_idx),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.wr_en   (rec_next.wr_en),	// Written on the edge that loads retire
		.wr_reg  (rec_next.wr_reg),
		.wr_data (rec_next.wr_data)
	);

	assign op_b = ctrl.use_imm ? imm : rt_data;

	alu u_alu (
		.a              (rs_data),
		.b              (op_b),
		.shamt          (shamt),
		.shift_by_shamt (ctrl.shift_by_shamt),
		.alu_op         (ctrl.alu_op),
		.branch         (ctrl.branch),
		.hi             (hi),
		.lo             (lo),
		.result         (result),
		.taken          (taken)
	);

	hi_lo_unit u_hilo (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (instr_valid),
		.hilo_op (ctrl.hilo_op),
		.a       (rs_data),
		.b       (rt_data),
		.hi      (hi),
		.lo      (lo)
	);

	always_comb begin
		rec_next.wr_en        = instr_valid && ctrl.reg_write && !ctrl.illegal;
		rec_next.wr_reg       = rd_sel;
		rec_next.wr_data      = result;
		rec_next.branch_taken = taken;
		rec_next.is_branch    = (ctrl.branch != mips_ctrl_pkg::BR_NONE);
		rec_next.illegal      = ctrl.illegal;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			retire_valid <= 1'b0;
		end else begin
			retire_valid <= instr_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (instr_valid) begin
			retire <= rec_next;
		end
	end

endmodule

// File: exec_core_asserts.sv
`timescale 1ns/1ps

module exec_core_asserts (
	input logic                          clk,
	input logic                          rst_n,
	input logic                          instr_valid,
	input logic [mips_isa_pkg::XLEN-1:0] instr,
	input logic                          retire_valid,
	input mips_ctrl_pkg::retire_t        retire
);

	logic [31:0] shadow [32];
	logic [31:0] sh_hi;
	logic [31:0] sh_lo;
	logic        exp_valid;
	mips_ctrl_pkg::retire_t exp_rec;
	int          fail_count = 0;	// Read by the testbench

	// Shadow registers and HI/LO fed from the instruction word only
	always @(posedge clk) begin
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] se;
		logic [31:0] res;
		logic [63:0] prod;
		logic [5:0]  op;
		logic [5:0]  fn;
		mips_ctrl_pkg::retire_t rec;
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				shadow[i] <= '0;
			end
			sh_hi     <= '0;
			sh_lo     <= '0;
			exp_valid <= 1'b0;
		end else begin
			op   = instr[31:26];
			fn   = instr[5:0];
			a    = shadow[instr[25:21]];
			b    = shadow[instr[20:16]];
			se   = {{16{instr[15]}}, instr[15:0]};
			res  = '0;
			prod = '0;
			rec  = '0;
			rec.wr_reg = (op == 6'd0) ? instr[15:11] : instr[20:16];
			rec.wr_en  = 1'b1;
			case (op)
				mips_isa_pkg::OP_SPECIAL: begin
					case (fn)
						mips_isa_pkg::FN_ADD, mips_isa_pkg::FN_ADDU: res = a + b;
						mips_isa_pkg::FN_SUB, mips_isa_pkg::FN_SUBU: res = a - b;
						mips_isa_pkg::FN_AND:  res = a & b;
						mips_isa_pkg::FN_OR:   res = a | b;
						mips_isa_pkg::FN_XOR:  res = a ^ b;
						mips_isa_pkg::FN_NOR:  res = ~(a | b);
						mips_isa_pkg::FN_SLT:  res = {31'd0, $signed(a) < $signed(b)};
						mips_isa_pkg::FN_SLTU: res = {31'd0, a < b};
						mips_isa_pkg::FN_SLL:  res = b << instr[10:6];
						mips_isa_pkg::FN_SRL:  res = b >> instr[10:6];
						mips_isa_pkg::FN_SRA:  res = $signed(b) >>> instr[10:6];
						mips_isa_pkg::FN_MFHI: res = sh_hi;
						mips_isa_pkg::FN_MFLO: res = sh_lo;
						mips_isa_pkg::FN_MULT: begin
							prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
							rec.wr_en = 1'b0;
						end
						mips_isa_pkg::FN_MULTU: begin
							prod = {32'd0, a} * {32'd0, b};
							rec.wr_en = 1'b0;
						end
						mips_isa_pkg::FN_DIV, mips_isa_pkg::FN_DIVU,
						mips_isa_pkg::FN_MTHI, mips_isa_pkg::FN_MTLO: rec.wr_en = 1'b0;
						default: rec.illegal = 1'b1;
					endcase
				end
				mips_isa_pkg::OP_REGIMM: begin
					rec.is_branch    = (instr[20:17] == 4'd0);
					rec.illegal      = !rec.is_branch;
					rec.branch_taken = rec.is_branch && (a[31] ^ instr[16]);	// BLTZ or BGEZ
				end
				mips_isa_pkg::OP_BEQ:  rec.branch_taken = (a == b);
				mips_isa_pkg::OP_BNE:  rec.branch_taken = (a != b);
				mips_isa_pkg::OP_BLEZ: rec.branch_taken = ($signed(a) <= 0);
				mips_isa_pkg::OP_BGTZ: rec.branch_taken = ($signed(a) > 0);
				mips_isa_pkg::OP_ADDI, mips_isa_pkg::OP_ADDIU: res = a + se;
				mips_isa_pkg::OP_SLTI:  res = {31'd0, $signed(a) < $signed(se)};
				mips_isa_pkg::OP_SLTIU: res = {31'd0, a < se};
				mips_isa_pkg::OP_ANDI:  res = a & {16'd0, instr[15:0]};
				mips_isa_pkg::OP_ORI:   res = a | {16'd0, instr[15:0]};
				mips_isa_pkg::OP_XORI:  res = a ^ {16'd0, instr[15:0]};
				mips_isa_pkg::OP_LUI:   res = {instr[15:0], 16'd0};
				default: rec.illegal = 1'b1;
			endcase
			if (op inside {6'h04, 6'h05, 6'h06, 6'h07}) begin
				rec.is_branch = 1'b1;
			end
			if (rec.is_branch || rec.illegal) begin
				rec.wr_en = 1'b0;
			end
			rec.wr_data = res;
			exp_valid <= instr_valid;
			if (instr_valid) begin
				exp_rec <= rec;
				if (rec.wr_en && rec.wr_reg != 5'd0) begin
					shadow[rec.wr_reg] <= res;
				end
				if (op == 6'd0) begin
					case (fn)
						mips_isa_pkg::FN_MULT, mips_isa_pkg::FN_MULTU: {sh_hi, sh_lo} <= prod;
						mips_isa_pkg::FN_DIV: begin
							if (b != 0) begin
								sh_lo <= $signed(a) / $signed(b);
								sh_hi <= $signed(a) % $signed(b);
							end
						end
						mips_isa_pkg::FN_DIVU: begin
							if (b != 0) begin
								sh_lo <= a / b;
								sh_hi <= a % b;
							end
						end
						mips_isa_pkg::FN_MTHI: sh_hi <= a;
						mips_isa_pkg::FN_MTLO: sh_lo <= a;
						default: begin
						end
					endcase
				end
			end
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) retire_valid == exp_valid)
		else begin
			$error("CHECK FAILED t=%0t: retire_valid is %b", $time, retire_valid);
			fail_count++;
		end

	assert property (@(posedge clk) disable iff (!rst_n) retire_valid |->
		retire.wr_en == exp_rec.wr_en && retire.illegal == exp_rec.illegal &&
		retire.is_branch == exp_rec.is_branch)
		else begin
			$error("CHECK FAILED t=%0t: retire flags wrong", $time);
			fail_count++;
		end

	assert property (@(posedge clk) disable iff (!rst_n) retire_valid && exp_rec.wr_en |->
		retire.wr_reg == exp_rec.wr_reg && retire.wr_data == exp_rec.wr_data)
		else begin
			$error("CHECK FAILED t=%0t: write r%0d data %h, expected r%0d data %h", $time,
				retire.wr_reg, retire.wr_data, exp_rec.wr_reg, exp_rec.wr_data);
			fail_count++;
		end

	assert property (@(posedge clk) disable iff (!rst_n) retire_valid && exp_rec.is_branch |->
		retire.branch_taken == exp_rec.branch_taken)
		else begin
			$error("CHECK FAILED t=%0t: branch_taken is %b", $time, retire.branch_taken);
			fail_count++;
		end

endmodule

bind exec_core exec_core_asserts u_checks (.*);

// File: files.f
mips_isa_pkg.sv
mips_ctrl_pkg.sv
control_unit.sv
alu.sv
register_file.sv
hi_lo_unit.sv
exec_core.sv
exec_core_asserts.sv
tb_exec_core.sv

// File: hi_lo_unit.sv
`timescale 1ns/1ps

module hi_lo_unit (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          start,
	input  mips_ctrl_pkg::hilo_op_e       hilo_op,
	input  logic [mips_isa_pkg::XLEN-1:0] a,
	input  logic [mips_isa_pkg::XLEN-1:0] b,
	output logic [mips_isa_pkg::XLEN-1:0] hi,
	output logic [mips_isa_pkg::XLEN-1:0] lo
);

	logic signed [mips_isa_pkg::XLEN-1:0]   a_s;
	logic signed [mips_isa_pkg::XLEN-1:0]   b_s;
	logic signed [mips_isa_pkg::XLEN-1:0]   d_s;
	logic [mips_isa_pkg::XLEN-1:0]          div_b;
	logic                                   div_zero;
	logic signed [2*mips_isa_pkg::XLEN-1:0] prod_s;
	logic [2*mips_isa_pkg::XLEN-1:0]        prod_u;
	logic [mips_isa_pkg::XLEN-1:0]          quot_s;
	logic [mips_isa_pkg::XLEN-1:0]          rem_s;
	logic [mips_isa_pkg::XLEN-1:0]          quot_u;
	logic [mips_isa_pkg::XLEN-1:0]          rem_u;

	assign div_zero = (b == '0);
	assign div_b    = b | {{(mips_isa_pkg::XLEN-1){1'b0}}, div_zero};	// Divisor 1 when b is zero
	assign a_s      = a;
	assign b_s      = b;
	assign d_s      = div_b;

	assign prod_s = a_s * b_s;	// Operands widen to 64 bits
	assign prod_u = a * b;
	assign quot_s = a_s / d_s;
	assign rem_s  = a_s % d_s;
	assign quot_u = a / div_b;
	assign rem_u  = a % div_b;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hi <= '0;
			lo <= '0;
		end else if (start) begin
			case (hilo_op)
				mips_ctrl_pkg::HL_MULT:  {hi, lo} <= prod_s;
				mips_ctrl_pkg::HL_MULTU: {hi, lo} <= prod_u;
				mips_ctrl_pkg::HL_DIV: begin
					if (!div_zero) begin
						lo <= quot_s;
						hi <= rem_s;
					end
				end
				mips_ctrl_pkg::HL_DIVU: begin
					if (!div_zero) begin
						lo <= quot_u;
						hi <= rem_u;
					end
				end
				mips_ctrl_pkg::HL_MTHI:  hi <= a;
				mips_ctrl_pkg::HL_MTLO:  lo <= a;
				default: begin
				end
			endcase
		end
	end

endmodule

// File: mips_ctrl_pkg.sv
package mips_ctrl_pkg;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT,
		ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_PASS_HI, ALU_PASS_LO
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE, BR_EQ, BR_NE, BR_LEZ, BR_GTZ, BR_LTZ, BR_GEZ
	} branch_e;

	typedef enum logic [2:0] {
		HL_NONE, HL_MULT, HL_MULTU, HL_DIV, HL_DIVU, HL_MTHI, HL_MTLO
	} hilo_op_e;

	typedef struct packed {
		logic     reg_write;
		logic     use_imm;		// Operand B from immediate
		logic     shift_by_shamt;
		alu_op_e  alu_op;
		branch_e  branch;
		hilo_op_e hilo_op;
		logic     illegal;
	} ctrl_t;

	typedef struct packed {
		logic                              wr_en;
		logic [mips_isa_pkg::REG_AW-1:0]   wr_reg;
		logic [mips_isa_pkg::XLEN-1:0]     wr_data;
		logic                              branch_taken;
		logic                              is_branch;
		logic                              illegal;
	} retire_t;

endpackage

// File: mips_isa_pkg.sv
package mips_isa_pkg;

	localparam int XLEN      = 32;
	localparam int REG_COUNT = 32;
	localparam int REG_AW    = $clog2(REG_COUNT);

	localparam int OP_W      = 6;
	localparam int FUNCT_W   = 6;
	localparam int IMM_W     = 16;

	localparam int OP_LSB    = 26;
	localparam int RS_LSB    = 21;
	localparam int RT_LSB    = 16;
	localparam int RD_LSB    = 11;
	localparam int SHAMT_LSB = 6;
	localparam int FUNCT_LSB = 0;
	localparam int IMM_LSB   = 0;

	typedef enum logic [OP_W-1:0] {
		OP_SPECIAL = 6'b000000,	// R-type, decoded by funct
		OP_REGIMM  = 6'b000001,	// BLTZ/BGEZ, decoded by rt
		OP_BEQ     = 6'b000100,
		OP_BNE     = 6'b000101,
		OP_BLEZ    = 6'b000110,
		OP_BGTZ    = 6'b000111,
		OP_ADDI    = 6'b001000,
		OP_ADDIU   = 6'b001001,
		OP_SLTI    = 6'b001010,
		OP_SLTIU   = 6'b001011,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_XORI    = 6'b001110,
		OP_LUI     = 6'b001111
	} opcode_e;

	typedef enum logic [FUNCT_W-1:0] {
		FN_SLL  = 6'b000000, FN_SRL  = 6'b000010, FN_SRA   = 6'b000011,
		FN_MFHI = 6'b010000, FN_MTHI = 6'b010001,
		FN_MFLO = 6'b010010, FN_MTLO = 6'b010011,
		FN_MULT = 6'b011000, FN_MULTU = 6'b011001,
		FN_DIV  = 6'b011010, FN_DIVU  = 6'b011011,
		FN_ADD  = 6'b100000, FN_ADDU = 6'b100001,
		FN_SUB  = 6'b100010, FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100, FN_OR   = 6'b100101,
		FN_XOR  = 6'b100110, FN_NOR  = 6'b100111,
		FN_SLT  = 6'b101010, FN_SLTU = 6'b101011
	} funct_e;

	localparam logic [REG_AW-1:0] REGIMM_BLTZ = 5'b00000;
	localparam logic [REG_AW-1:0] REGIMM_BGEZ = 5'b00001;

endpackage

// File: register_file.sv
`timescale 1ns/1ps

module register_file (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [mips_isa_pkg::REG_AW-1:0] rs_idx,
	input  logic [mips_isa_pkg::REG_AW-1:0] rt_idx,
	output logic [mips_isa_pkg::XLEN-1:0]   rs_data,
	output logic [mips_isa_pkg::XLEN-1:0]   rt_data,
	input  logic                            wr_en,
	input  logic [mips_isa_pkg::REG_AW-1:0] wr_reg,
	input  logic [mips_isa_pkg::XLEN-1:0]   wr_data
);

	logic [mips_isa_pkg::XLEN-1:0] regs [mips_isa_pkg::REG_COUNT];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < mips_isa_pkg::REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_reg != '0)) begin	// $zero is never written
			regs[wr_reg] <= wr_data;
		end
	end

	assign rs_data = (rs_idx == '0) ? '0 : regs[rs_idx];
	assign rt_data = (rt_idx == '0) ? '0 : regs[rt_idx];

endmodule

// File: tb_exec_core.sv
`timescale 1ns/1ps

module tb_exec_core;

	localparam int WAIT_LIMIT   = 10;
	localparam int RANDOM_COUNT = 600;

	localparam logic [5:0] ALU_FN [13] = '{
		mips_isa_pkg::FN_ADD, mips_isa_pkg::FN_ADDU, mips_isa_pkg::FN_SUB, mips_isa_pkg::FN_SUBU,
		mips_isa_pkg::FN_AND, mips_isa_pkg::FN_OR, mips_isa_pkg::FN_XOR, mips_isa_pkg::FN_NOR,
		mips_isa_pkg::FN_SLT, mips_isa_pkg::FN_SLTU, mips_isa_pkg::FN_SLL, mips_isa_pkg::FN_SRL,
		mips_isa_pkg::FN_SRA};
	localparam logic [5:0] HILO_FN [8] = '{
		mips_isa_pkg::FN_MULT, mips_isa_pkg::FN_MULTU, mips_isa_pkg::FN_DIV, mips_isa_pkg::FN_DIVU,
		mips_isa_pkg::FN_MTHI, mips_isa_pkg::FN_MTLO, mips_isa_pkg::FN_MFHI, mips_isa_pkg::FN_MFLO};
	localparam logic [5:0] IMM_OP [8] = '{
		mips_isa_pkg::OP_ADDI, mips_isa_pkg::OP_ADDIU, mips_isa_pkg::OP_SLTI, mips_isa_pkg::OP_SLTIU,
		mips_isa_pkg::OP_ANDI, mips_isa_pkg::OP_ORI, mips_isa_pkg::OP_XORI, mips_isa_pkg::OP_LUI};
	localparam logic [5:0] BR_OP [4] = '{
		mips_isa_pkg::OP_BEQ, mips_isa_pkg::OP_BNE, mips_isa_pkg::OP_BLEZ, mips_isa_pkg::OP_BGTZ};
	localparam logic [5:0] BAD_OP [4] = '{6'h02, 6'h23, 6'h2b, 6'h3f};	// J, LW, SW, unused

	logic                   clk = 1'b0;
	logic                   rst_n;
	logic                   instr_valid;
	logic [31:0]            instr;
	logic                   retire_valid;
	mips_ctrl_pkg::retire_t retire;
	int                     seed = 32'he7dad2f0;

	always #20 clk = ~clk;

	exec_core DUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.retire_valid (retire_valid),
		.retire       (retire)
	);

	function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] sh, input logic [5:0] fn);
		return {6'd0, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic int pick(input int n);
		return {$random(seed)} % n;
	endfunction

	// Registers r0..r7 only, so results feed later instructions
	function automatic logic [31:0] random_instr();
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		rs = 5'(pick(8));
		rt = 5'(pick(8));
		rd = 5'(pick(8));
		case (pick(10))
			0, 1, 2: return r_type(rs, rt, rd, 5'(pick(32)), ALU_FN[pick(13)]);
			3, 4:    return r_type(rs, rt, rd, 5'd0, HILO_FN[pick(8)]);
			5, 6:    return i_type(IMM_OP[pick(8)], rs, rt, 16'(pick(65536)));
			7:       return i_type(BR_OP[pick(4)], rs, rt, 16'd4);
			8:       return i_type(mips_isa_pkg::OP_REGIMM, rs, 5'(pick(4)), 16'd4);	// rt 2, 3 illegal
			default: return i_type(BAD_OP[pick(4)], rs, rt, 16'(pick(65536)));
		endcase
	endfunction

	// Starts and ends just after a rising edge
	task automatic await_retire();
		int n;
		for (n = 0; n < WAIT_LIMIT; n++) begin
			@(negedge clk);
			if (retire_valid) break;
		end
		if (n == WAIT_LIMIT) begin
			$display("Timeout: retire_valid did not rise within %0d cycles at %0t",
				WAIT_LIMIT, $time);
			$display("TEST FAIL");
			$fatal(1, "retire timeout");
		end
		@(posedge clk);
	endtask

	task automatic issue(input logic [31:0] word, input bit burst);
		instr_valid <= 1'b1;
		instr       <= word;
		@(posedge clk);
		if (!burst) begin
			instr_valid <= 1'b0;
			await_retire();
		end
	endtask

	always @(negedge clk) begin
		if (DUT.u_checks.fail_count != 0) begin
			$display("TEST FAIL");
			$fatal(1, "retire checker reported a mismatch");
		end
	end

	initial begin
		bit burst;
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		repeat (4) @(posedge clk);		// Idle with no strobe
		issue(i_type(mips_isa_pkg::OP_ORI, 5'd0, 5'd1, 16'h1234), 1'b0);
		issue(i_type(mips_isa_pkg::OP_LUI, 5'd0, 5'd2, 16'h8000), 1'b0);
		issue(i_type(mips_isa_pkg::OP_ORI, 5'd2, 5'd2, 16'h0005), 1'b1);
		issue(i_type(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd3, 16'hfff9), 1'b0);
		issue(i_type(mips_isa_pkg::OP_ORI, 5'd0, 5'd4, 16'h0003), 1'b0);
		issue(r_type(5'd2, 5'd3, 5'd0, 5'd0, mips_isa_pkg::FN_MULT), 1'b0);
		issue(r_type(5'd0, 5'd0, 5'd6, 5'd0, mips_isa_pkg::FN_MFHI), 1'b0);
		issue(r_type(5'd0, 5'd0, 5'd7, 5'd0, mips_isa_pkg::FN_MFLO), 1'b0);
		issue(r_type(5'd3, 5'd4, 5'd0, 5'd0, mips_isa_pkg::FN_DIV), 1'b0);
		issue(r_type(5'd0, 5'd0, 5'd6, 5'd0, mips_isa_pkg::FN_MFHI), 1'b0);
		issue(r_type(5'd1, 5'd0, 5'd0, 5'd0, mips_isa_pkg::FN_DIVU), 1'b0);	// Divide by zero
		issue(r_type(5'd0, 5'd0, 5'd7, 5'd0, mips_isa_pkg::FN_MFLO), 1'b0);
		issue(r_type(5'd1, 5'd0, 5'd0, 5'd0, mips_isa_pkg::FN_MTHI), 1'b0);
		issue(r_type(5'd0, 5'd0, 5'd5, 5'd0, mips_isa_pkg::FN_MFHI), 1'b0);
		issue(i_type(mips_isa_pkg::OP_ADDIU, 5'd1, 5'd0, 16'h0001), 1'b0);
		issue(r_type(5'd0, 5'd1, 5'd7, 5'd0, mips_isa_pkg::FN_ADD), 1'b0);
		issue(i_type(mips_isa_pkg::OP_BEQ, 5'd1, 5'd1, 16'h0004), 1'b0);
		issue(i_type(mips_isa_pkg::OP_REGIMM, 5'd2, mips_isa_pkg::REGIMM_BLTZ, 16'h0004), 1'b0);
		issue(i_type(6'h23, 5'd1, 5'd2, 16'h0000), 1'b0);
		for (int i = 0; i < RANDOM_COUNT; i++) begin
			burst = (pick(4) == 0) && (i != RANDOM_COUNT - 1);
			issue(random_instr(), burst);
			if (!burst) begin
				repeat (pick(3)) @(posedge clk);
			end
		end
		repeat (3) @(posedge clk);
		if (DUT.u_checks.fail_count == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			$display("TEST FAIL");
			$fatal(1, "retire checker reported a mismatch");
		end
	end

endmodule
